// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module decode_stage_tb \
  -o decode_stage_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/decode_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1

// ==== sim.f ====
source/isa_pkg.sv
source/pipeline_pkg.sv
source/register_file.sv
source/operand_bypass.sv
source/instruction_decoder.sv
source/branch_resolver.sv
source/stage_control.sv
source/decode_stage.sv
sim/clock_gen.sv
sim/decode_stage_properties.sv
sim/decode_stage_tb.sv

// ==== sim/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // reset held for four rising edges
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/decode_stage_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage_properties (
  input logic clock,
  input logic reset,
  input logic out_valid,
  input logic allow_in,
  input logic exec_allow_in,
  input pipeline_pkg::fetch_bus_t held
);

  empty_after_reset: assert property (
    @(posedge clock) reset |=> !out_valid
  ) else $error("out_valid high in the cycle after reset");

  // execute refuses, so nothing new may enter
  blocked_when_full: assert property (
    @(posedge clock) disable iff (reset)
    (out_valid && !exec_allow_in) |-> !allow_in
  ) else $error("allow_in high while the stage is blocked");

  held_stable: assert property (
    @(posedge clock) disable iff (reset)
    (out_valid && !exec_allow_in) |=> $stable(held)
  ) else $error("held instruction changed while blocked");

endmodule

`default_nettype wire

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;
  import isa_pkg::*;
  import pipeline_pkg::*;

  localparam int random_tests = 150;
  localparam int test_count = 3 * random_tests + register_count + 10;
  localparam logic [5:0] r_functions [11] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
    fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
  localparam logic [5:0] i_opcodes [8] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori,
    op_xori, op_lw, op_sw};

  logic clock;
  logic reset;
  fetch_bus_t fetch_bus;
  logic allow_in;
  logic exec_allow_in;
  bypass_bus_t exec_bypass;
  bypass_bus_t memory_bypass;
  bypass_bus_t writeback_bypass;
  reg_write_t reg_write;
  decode_bus_t decode_bus;
  branch_bus_t branch_bus;

  logic [31:0] lfsr_state = 32'd87788;
  logic model_valid = 1'b0;
  fetch_bus_t model_held;
  logic expected_allow_in = 1'b1;
  word_t shadow [register_count];
  int error_count = 0;
  int check_count = 0;

  clock_gen clock_gen_i (.clock(clock), .reset(reset));

  decode_stage decode_stage_i (
    .clock(clock),
    .reset(reset),
    .fetch_bus(fetch_bus),
    .allow_in(allow_in),
    .exec_allow_in(exec_allow_in),
    .exec_bypass(exec_bypass),
    .memory_bypass(memory_bypass),
    .writeback_bypass(writeback_bypass),
    .reg_write(reg_write),
    .decode_bus(decode_bus),
    .branch_bus(branch_bus)
  );

  bind stage_control decode_stage_properties decode_stage_properties_i (
    .clock(clock),
    .reset(reset),
    .out_valid(out_valid),
    .allow_in(allow_in),
    .exec_allow_in(exec_allow_in),
    .held(held)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] result;
    logic feedback;
    result = '0;
    for (int n = 0; n < width; n++) begin
      feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      result = {result[30:0], feedback};
    end
    return result;
  endfunction

  function automatic decode_control_t reference_control(input instruction_t i);
    decode_control_t c;
    logic [5:0] op;
    logic [5:0] fn;
    op = i[31:26];
    fn = i[5:0];
    c = '0;
    c.alu_op = alu_none;
    c.branch_kind = branch_none;
    if (op == op_special && i[10:6] == 5'd0 &&
        fn inside {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu}) begin
      c.register_write = 1'b1;
      c.write_register = i[15:11];
      c.uses_rs = 1'b1;
      c.uses_rt = 1'b1;
      case (fn)
        fn_addu: c.alu_op = alu_add;
        fn_subu: c.alu_op = alu_sub;
        fn_and: c.alu_op = alu_and;
        fn_or: c.alu_op = alu_or;
        fn_xor: c.alu_op = alu_xor;
        fn_nor: c.alu_op = alu_nor;
        fn_slt: c.alu_op = alu_slt;
        default: c.alu_op = alu_sltu;
      endcase
    end else if (op == op_special && i[25:21] == 5'd0 && fn inside {fn_sll, fn_srl, fn_sra}) begin
      c.register_write = 1'b1;
      c.write_register = i[15:11];
      c.uses_rt = 1'b1;
      c.source1_is_shift_amount = 1'b1;
      c.alu_op = (fn == fn_sll) ? alu_sll : (fn == fn_srl) ? alu_srl : alu_sra;
    end else if (op == op_special && fn == fn_jr && i[20:6] == 15'd0) begin
      c.branch_kind = branch_register;
      c.uses_rs = 1'b1;
    end else if (op inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lw} ||
        (op == op_lui && i[25:21] == 5'd0)) begin
      c.register_write = 1'b1;
      c.write_register = i[20:16];
      c.source2_is_immediate = 1'b1;
      c.uses_rs = op != op_lui;
      c.is_load = op == op_lw;
      c.source2_is_unsigned = op inside {op_andi, op_ori, op_xori};
      case (op)
        op_slti: c.alu_op = alu_slt;
        op_sltiu: c.alu_op = alu_sltu;
        op_andi: c.alu_op = alu_and;
        op_ori: c.alu_op = alu_or;
        op_xori: c.alu_op = alu_xor;
        op_lui: c.alu_op = alu_lui;
        default: c.alu_op = alu_add;
      endcase
    end else if (op == op_sw) begin
      c.alu_op = alu_add;
      c.source2_is_immediate = 1'b1;
      c.memory_write = 1'b1;
      c.uses_rs = 1'b1;
      c.uses_rt = 1'b1;
    end else if (op == op_beq || op == op_bne) begin
      c.branch_kind = (op == op_beq) ? branch_eq : branch_ne;
      c.uses_rs = 1'b1;
      c.uses_rt = 1'b1;
    end else if (op == op_j) begin
      c.branch_kind = branch_jump;
    end else if (op == op_jal) begin
      c.branch_kind = branch_jump;
      c.alu_op = alu_add;
      c.source1_is_program_count = 1'b1;
      c.source2_is_8 = 1'b1;
      c.register_write = 1'b1;
      c.write_register = 5'd31;
    end
    return c;
  endfunction

  function automatic word_t reference_operand(input reg_address_t source);
    if (source == 5'd0) return '0;
    if (exec_bypass.valid && exec_bypass.data_valid && exec_bypass.write_register == source)
      return exec_bypass.write_data;
    if (memory_bypass.valid && memory_bypass.data_valid &&
        memory_bypass.write_register == source)
      return memory_bypass.write_data;
    if (writeback_bypass.valid && writeback_bypass.data_valid &&
        writeback_bypass.write_register == source)
      return writeback_bypass.write_data;
    return shadow[source];
  endfunction

  function automatic logic hits_source(input bypass_bus_t entry, input decode_control_t c,
      input reg_address_t rs, input reg_address_t rt);
    return entry.valid && entry.write_register != 5'd0 &&
      ((c.uses_rs && entry.write_register == rs) || (c.uses_rt && entry.write_register == rt));
  endfunction

  task automatic report_mismatch(input string name, input string expected, input string actual);
    error_count++;
    $display("[ERROR] %0t %s expected %s actual %s", $time, name, expected, actual);
  endtask

  task automatic check_outputs();
    decode_control_t c;
    reg_address_t rs;
    reg_address_t rt;
    logic ready;
    logic exp_valid;
    logic exp_allow;
    logic condition;
    word_t rs_v;
    word_t rt_v;
    word_t next;
    word_t exp_target;
    c = reference_control(model_held.instruction);
    rs = model_held.instruction[25:21];
    rt = model_held.instruction[20:16];
    ready = !((!exec_bypass.data_valid && hits_source(exec_bypass, c, rs, rt)) ||
      (!memory_bypass.data_valid && hits_source(memory_bypass, c, rs, rt)) ||
      (c.branch_kind inside {branch_eq, branch_ne, branch_register} &&
        hits_source(exec_bypass, c, rs, rt)));
    exp_valid = model_valid && ready;
    exp_allow = !model_valid || (ready && exec_allow_in);
    rs_v = reference_operand(rs);
    rt_v = reference_operand(rt);
    next = model_held.program_count + 32'd4;
    condition = c.branch_kind inside {branch_jump, branch_register} ||
      (c.branch_kind == branch_eq && rs_v == rt_v) ||
      (c.branch_kind == branch_ne && rs_v != rt_v);
    if (c.branch_kind == branch_jump)
      exp_target = {next[31:28], model_held.instruction[25:0], 2'b00};
    else if (c.branch_kind == branch_register)
      exp_target = rs_v;
    else
      exp_target = next + {{14{model_held.instruction[15]}}, model_held.instruction[15:0], 2'b00};
    check_count++;
    if (allow_in !== exp_allow)
      report_mismatch("allow_in", $sformatf("%b", exp_allow), $sformatf("%b", allow_in));
    if (decode_bus.valid !== exp_valid)
      report_mismatch("decode_bus.valid", $sformatf("%b", exp_valid),
        $sformatf("%b", decode_bus.valid));
    if (branch_bus.taken !== (exp_valid && condition))
      report_mismatch("branch_bus.taken", $sformatf("%b", exp_valid && condition),
        $sformatf("%b", branch_bus.taken));
    if (exp_valid && condition && branch_bus.target !== exp_target)
      report_mismatch("branch_bus.target", $sformatf("%h", exp_target),
        $sformatf("%h", branch_bus.target));
    if (model_valid && decode_bus.control !== c)
      report_mismatch("decode_bus.control", $sformatf("%h", c),
        $sformatf("%h", decode_bus.control));
    if (model_valid && decode_bus.program_count !== model_held.program_count)
      report_mismatch("decode_bus.program_count", $sformatf("%h", model_held.program_count),
        $sformatf("%h", decode_bus.program_count));
    if (model_valid && decode_bus.rs_value !== rs_v)
      report_mismatch("decode_bus.rs_value", $sformatf("%h", rs_v),
        $sformatf("%h", decode_bus.rs_value));
    if (model_valid && decode_bus.rt_value !== rt_v)
      report_mismatch("decode_bus.rt_value", $sformatf("%h", rt_v),
        $sformatf("%h", decode_bus.rt_value));
    if (model_valid && decode_bus.immediate !== model_held.instruction[15:0])
      report_mismatch("decode_bus.immediate", $sformatf("%h", model_held.instruction[15:0]),
        $sformatf("%h", decode_bus.immediate));
    if (model_valid && decode_bus.shift_amount !== model_held.instruction[10:6])
      report_mismatch("decode_bus.shift_amount", $sformatf("%h", model_held.instruction[10:6]),
        $sformatf("%h", decode_bus.shift_amount));
    expected_allow_in = exp_allow;
  endtask

  always @(negedge clock) begin
    check_outputs();
  end

  // stage model and shadow registers advance on the edge
  always @(posedge clock) begin
    if (reg_write.write_enabled && reg_write.write_address != 5'd0)
      shadow[reg_write.write_address] <= reg_write.write_data;
    if (reset) begin
      model_valid <= 1'b0;
    end else if (expected_allow_in) begin
      model_valid <= fetch_bus.valid;
      if (fetch_bus.valid) model_held <= fetch_bus;
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic bypass_bus_t random_entry();
    bypass_bus_t e;
    logic [31:0] bits;
    bits = random_bits(5);
    e.write_register = bits[4:0];
    bits = random_bits(2);
    if (model_valid && bits[1:0] == 2'd0) e.write_register = model_held.instruction[25:21];
    if (model_valid && bits[1:0] == 2'd1) e.write_register = model_held.instruction[20:16];
    e.valid = random_bits(1) == 1;
    e.data_valid = random_bits(2) != 0;
    e.write_data = random_bits(32);
    return e;
  endfunction

  // mode 0 no bypass, 1 random bypass, 2 leave bypass alone
  task automatic randomize_side_inputs(input int mode);
    logic [31:0] bits;
    if (mode == 2) return;
    exec_allow_in = random_bits(2) != 0;
    reg_write.write_enabled = random_bits(1) == 1;
    bits = random_bits(5);
    reg_write.write_address = bits[4:0];
    reg_write.write_data = random_bits(32);
    if (mode == 1) begin
      exec_bypass = random_entry();
      memory_bypass = random_entry();
      writeback_bypass = random_entry();
    end
  endtask

  function automatic instruction_t random_instruction(input logic branches_only);
    int kind;
    logic [31:0] bits;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    kind = branches_only ? 20 + int'(random_bits(8) % 5) : int'(random_bits(8) % 28);
    bits = random_bits(15);
    rs = bits[14:10];
    rt = bits[9:5];
    rd = bits[4:0];
    if (random_bits(1) == 1) rt = rs;
    bits = random_bits(16);
    if (kind < 8) return {op_special, rs, rt, rd, 5'd0, r_functions[kind]};
    if (kind < 11) return {op_special, 5'd0, rt, rd, bits[4:0], r_functions[kind]};
    if (kind < 19) return {i_opcodes[kind - 11], rs, rt, bits[15:0]};
    case (kind)
      19: return {op_lui, 5'd0, rt, bits[15:0]};
      20: return {op_beq, rs, rt, bits[15:0]};
      21: return {op_bne, rs, rt, bits[15:0]};
      22: return {op_j, rs, rt, bits[15:0]};
      23: return {op_jal, rs, rt, bits[15:0]};
      24: return {op_special, rs, 15'd0, fn_jr};
      default: return random_bits(32);
    endcase
  endfunction

  task automatic issue(input instruction_t instruction, input int mode);
    logic accepted;
    logic [31:0] bits;
    bits = random_bits(30);
    fetch_bus = '{valid: 1'b1, program_count: {bits[29:0], 2'b00}, instruction: instruction};
    randomize_side_inputs(mode);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = allow_in;
      next_cycle();
      randomize_side_inputs(mode);
    end
    fetch_bus.valid = 1'b0;
  endtask

  initial begin
    #((test_count * 20 + 100) * 100);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    fetch_bus = '0;
    exec_allow_in = 1'b1;
    exec_bypass = '0;
    memory_bypass = '0;
    writeback_bypass = '0;
    reg_write = '0;
    while (reset !== 1'b0) next_cycle();
    // load every register, register 0 included
    for (int r = 0; r < register_count; r++) begin
      reg_write = '{write_enabled: 1'b1, write_address: 5'(r), write_data: random_bits(32)};
      next_cycle();
    end
    repeat (random_tests) issue(random_instruction(1'b0), 0);
    repeat (random_tests) issue(random_instruction(1'b0), 1);
    exec_bypass = '0;
    memory_bypass = '0;
    writeback_bypass = '0;
    reg_write = '0;
    exec_allow_in = 1'b1;
    issue({op_special, 5'd1, 5'd2, 5'd3, 5'd0, fn_addu}, 2);
    // load in execute feeds rs of the addu now held
    exec_bypass = '{valid: 1'b1, data_valid: 1'b0, write_register: 5'd1, write_data: 32'h1234};
    repeat (3) begin
      @(negedge clock);
      if (decode_bus.valid !== 1'b0 || allow_in !== 1'b0) begin
        error_count++;
        $display("load-use stall did not hold the instruction at %0t", $time);
      end
      next_cycle();
    end
    exec_allow_in = 1'b0;
    exec_bypass.data_valid = 1'b1;
    repeat (3) next_cycle();
    exec_allow_in = 1'b1;
    next_cycle();
    exec_bypass = '0;
    repeat (random_tests) issue(random_instruction(1'b1), 1);
    exec_bypass = '0;
    memory_bypass = '0;
    writeback_bypass = '0;
    reg_write = '0;
    exec_allow_in = 1'b1;
    repeat (3) next_cycle();
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/branch_resolver.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_resolver (
  input  isa_pkg::branch_kind_t     branch_kind,
  input  isa_pkg::instruction_t     instruction,
  input  isa_pkg::word_t            program_count,
  input  isa_pkg::word_t            rs_value,
  input  isa_pkg::word_t            rt_value,
  input  logic                      valid,
  output pipeline_pkg::branch_bus_t branch_bus
);
  import isa_pkg::*;

  word_t next_sequential;
  word_t branch_offset;
  word_t jump_target;
  word_t target;
  logic operands_equal;
  logic condition;

  assign next_sequential = program_count + 32'd4;
  assign branch_offset = {{14{instruction[15]}}, instruction[15:0], 2'b00};
  // region of the delay slot
  assign jump_target = {next_sequential[31:28], instruction[25:0], 2'b00};
  assign operands_equal = rs_value == rt_value;

  always_comb begin
    case (branch_kind)
      branch_eq: begin
        condition = operands_equal;
        target = next_sequential + branch_offset;
      end
      branch_ne: begin
        condition = !operands_equal;
        target = next_sequential + branch_offset;
      end
      branch_jump: begin
        condition = 1'b1;
        target = jump_target;
      end
      branch_register: begin
        condition = 1'b1;
        target = rs_value;
      end
      default: begin
        condition = 1'b0;
        target = next_sequential;
      end
    endcase
  end

  assign branch_bus = '{taken: condition && valid, target: target};

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  pipeline_pkg::fetch_bus_t  fetch_bus,
  output logic                      allow_in,
  input  logic                      exec_allow_in,
  input  pipeline_pkg::bypass_bus_t exec_bypass,
  input  pipeline_pkg::bypass_bus_t memory_bypass,
  input  pipeline_pkg::bypass_bus_t writeback_bypass,
  input  pipeline_pkg::reg_write_t  reg_write,
  output pipeline_pkg::decode_bus_t decode_bus,
  output pipeline_pkg::branch_bus_t branch_bus
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  fetch_bus_t held;
  logic out_valid;
  decode_control_t control;
  reg_address_t rs;
  reg_address_t rt;
  word_t rs_file_value;
  word_t rt_file_value;
  word_t rs_value;
  word_t rt_value;

  assign rs = held.instruction[25:21];
  assign rt = held.instruction[20:16];

  stage_control stage_control_i (
    .clock(clock),
    .reset(reset),
    .fetch_bus(fetch_bus),
    .allow_in(allow_in),
    .exec_allow_in(exec_allow_in),
    .control(control),
    .rs(rs),
    .rt(rt),
    .exec_bypass(exec_bypass),
    .memory_bypass(memory_bypass),
    .held(held),
    .out_valid(out_valid)
  );

  instruction_decoder instruction_decoder_i (
    .instruction(held.instruction),
    .control(control)
  );

  register_file register_file_i (
    .clock(clock),
    .read_address_1(rs),
    .read_address_2(rt),
    .read_data_1(rs_file_value),
    .read_data_2(rt_file_value),
    .write(reg_write)
  );

  operand_bypass rs_bypass_i (
    .source(rs),
    .file_value(rs_file_value),
    .exec_bypass(exec_bypass),
    .memory_bypass(memory_bypass),
    .writeback_bypass(writeback_bypass),
    .value(rs_value)
  );

  operand_bypass rt_bypass_i (
    .source(rt),
    .file_value(rt_file_value),
    .exec_bypass(exec_bypass),
    .memory_bypass(memory_bypass),
    .writeback_bypass(writeback_bypass),
    .value(rt_value)
  );

  branch_resolver branch_resolver_i (
    .branch_kind(control.branch_kind),
    .instruction(held.instruction),
    .program_count(held.program_count),
    .rs_value(rs_value),
    .rt_value(rt_value),
    .valid(out_valid),
    .branch_bus(branch_bus)
  );

  assign decode_bus = '{
    valid: out_valid,
    program_count: held.program_count,
    rs_value: rs_value,
    rt_value: rt_value,
    immediate: held.instruction[15:0],
    shift_amount: held.instruction[10:6],
    control: control
  };

endmodule

`default_nettype wire

// ==== source/instruction_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instruction_decoder (
  input  isa_pkg::instruction_t         instruction,
  output pipeline_pkg::decode_control_t control
);
  import isa_pkg::*;

  logic [5:0] opcode;
  reg_address_t rs;
  reg_address_t rt;
  reg_address_t rd;
  logic [4:0] shift_amount;
  logic [5:0] function_code;
  logic special;
  logic register_alu;
  logic shift_immediate;
  logic is_jr;
  logic is_lui;
  logic immediate_alu;

  assign opcode = instruction[31:26];
  assign rs = instruction[25:21];
  assign rt = instruction[20:16];
  assign rd = instruction[15:11];
  assign shift_amount = instruction[10:6];
  assign function_code = instruction[5:0];

  assign special = opcode == op_special;
  // three-register forms require a zero shift amount
  assign register_alu = special && shift_amount == 5'd0 && function_code inside
    {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
  assign shift_immediate = special && rs == 5'd0 &&
    function_code inside {fn_sll, fn_srl, fn_sra};
  assign is_jr = special && function_code == fn_jr && rt == 5'd0 && rd == 5'd0 &&
    shift_amount == 5'd0;
  assign is_lui = opcode == op_lui && rs == 5'd0;
  assign immediate_alu = opcode inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori};

  always_comb begin
    control = '0;
    control.alu_op = alu_none;
    control.branch_kind = branch_none;
    if (register_alu || shift_immediate) begin
      control.register_write = 1'b1;
      control.write_register = rd;
      control.uses_rs = register_alu;
      control.uses_rt = 1'b1;
      control.source1_is_shift_amount = shift_immediate;
      case (function_code)
        fn_addu: control.alu_op = alu_add;
        fn_subu: control.alu_op = alu_sub;
        fn_and: control.alu_op = alu_and;
        fn_or: control.alu_op = alu_or;
        fn_xor: control.alu_op = alu_xor;
        fn_nor: control.alu_op = alu_nor;
        fn_slt: control.alu_op = alu_slt;
        fn_sltu: control.alu_op = alu_sltu;
        fn_sll: control.alu_op = alu_sll;
        fn_srl: control.alu_op = alu_srl;
        default: control.alu_op = alu_sra;
      endcase
    end else if (is_jr) begin
      control.branch_kind = branch_register;
      control.uses_rs = 1'b1;
    end else if (immediate_alu || is_lui || opcode == op_lw) begin
      control.register_write = 1'b1;
      control.write_register = rt;
      control.source2_is_immediate = 1'b1;
      control.uses_rs = !is_lui;
      control.is_load = opcode == op_lw;
      control.source2_is_unsigned = opcode inside {op_andi, op_ori, op_xori};
      case (opcode)
        op_slti: control.alu_op = alu_slt;
        op_sltiu: control.alu_op = alu_sltu;
        op_andi: control.alu_op = alu_and;
        op_ori: control.alu_op = alu_or;
        op_xori: control.alu_op = alu_xor;
        op_lui: control.alu_op = alu_lui;
        // addiu and lw both add
        default: control.alu_op = alu_add;
      endcase
    end else begin
      case (opcode)
        op_sw: begin
          control.alu_op = alu_add;
          control.source2_is_immediate = 1'b1;
          control.memory_write = 1'b1;
          control.uses_rs = 1'b1;
          control.uses_rt = 1'b1;
        end
        op_beq, op_bne: begin
          control.branch_kind = (opcode == op_beq) ? branch_eq : branch_ne;
          control.uses_rs = 1'b1;
          control.uses_rt = 1'b1;
        end
        op_j: control.branch_kind = branch_jump;
        op_jal: begin
          // link value is pc + 8, computed in execute
          control.branch_kind = branch_jump;
          control.alu_op = alu_add;
          control.source1_is_program_count = 1'b1;
          control.source2_is_8 = 1'b1;
          control.register_write = 1'b1;
          control.write_register = link_register;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int data_width = 32;
  localparam int reg_address_width = 5;
  localparam int register_count = 32;

  typedef logic [data_width-1:0] instruction_t;
  typedef logic [data_width-1:0] word_t;
  typedef logic [reg_address_width-1:0] reg_address_t;

  // jal writes its return address here
  localparam reg_address_t link_register = 5'd31;

  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j = 6'h02;
  localparam logic [5:0] op_jal = 6'h03;
  localparam logic [5:0] op_beq = 6'h04;
  localparam logic [5:0] op_bne = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_slti = 6'h0a;
  localparam logic [5:0] op_sltiu = 6'h0b;
  localparam logic [5:0] op_andi = 6'h0c;
  localparam logic [5:0] op_ori = 6'h0d;
  localparam logic [5:0] op_xori = 6'h0e;
  localparam logic [5:0] op_lui = 6'h0f;
  localparam logic [5:0] op_lw = 6'h23;
  localparam logic [5:0] op_sw = 6'h2b;

  // function field of special opcode
  localparam logic [5:0] fn_sll = 6'h00;
  localparam logic [5:0] fn_srl = 6'h02;
  localparam logic [5:0] fn_sra = 6'h03;
  localparam logic [5:0] fn_jr = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_nor = 6'h27;
  localparam logic [5:0] fn_slt = 6'h2a;
  localparam logic [5:0] fn_sltu = 6'h2b;

  typedef enum logic [3:0] {
    alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_t;

  typedef enum logic [2:0] {
    branch_none, branch_eq, branch_ne, branch_jump, branch_register
  } branch_kind_t;

endpackage

`default_nettype wire

// ==== source/operand_bypass.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
  input  isa_pkg::reg_address_t     source,
  input  isa_pkg::word_t            file_value,
  input  pipeline_pkg::bypass_bus_t exec_bypass,
  input  pipeline_pkg::bypass_bus_t memory_bypass,
  input  pipeline_pkg::bypass_bus_t writeback_bypass,
  output isa_pkg::word_t            value
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  function automatic logic forwards(input bypass_bus_t entry, input reg_address_t address);
    return entry.valid && entry.data_valid && entry.write_register == address;
  endfunction

  // youngest producer wins
  always_comb begin
    if (source == '0) begin
      value = '0;
    end else if (forwards(exec_bypass, source)) begin
      value = exec_bypass.write_data;
    end else if (forwards(memory_bypass, source)) begin
      value = memory_bypass.write_data;
    end else if (forwards(writeback_bypass, source)) begin
      value = writeback_bypass.write_data;
    end else begin
      value = file_value;
    end
  end

endmodule

`default_nettype wire

// ==== source/pipeline_pkg.sv ====
`default_nettype none

package pipeline_pkg;

  typedef struct packed {
    logic valid;
    isa_pkg::word_t program_count;
    isa_pkg::instruction_t instruction;
  } fetch_bus_t;

  // data_valid low while the value is still being produced
  typedef struct packed {
    logic valid;
    logic data_valid;
    isa_pkg::reg_address_t write_register;
    isa_pkg::word_t write_data;
  } bypass_bus_t;

  typedef struct packed {
    logic write_enabled;
    isa_pkg::reg_address_t write_address;
    isa_pkg::word_t write_data;
  } reg_write_t;

  typedef struct packed {
    isa_pkg::alu_op_t alu_op;
    isa_pkg::branch_kind_t branch_kind;
    logic source1_is_shift_amount;
    logic source1_is_program_count;
    logic source2_is_immediate;
    logic source2_is_unsigned;
    // jal adds 8 to the program count
    logic source2_is_8;
    logic memory_write;
    logic is_load;
    logic register_write;
    isa_pkg::reg_address_t write_register;
    logic uses_rs;
    logic uses_rt;
  } decode_control_t;

  typedef struct packed {
    logic valid;
    isa_pkg::word_t program_count;
    isa_pkg::word_t rs_value;
    isa_pkg::word_t rt_value;
    logic [15:0] immediate;
    logic [4:0] shift_amount;
    decode_control_t control;
  } decode_bus_t;

  typedef struct packed {
    logic taken;
    isa_pkg::word_t target;
  } branch_bus_t;

endpackage

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                     clock,
  input  isa_pkg::reg_address_t    read_address_1,
  input  isa_pkg::reg_address_t    read_address_2,
  output isa_pkg::word_t           read_data_1,
  output isa_pkg::word_t           read_data_2,
  input  pipeline_pkg::reg_write_t write
);
  import isa_pkg::*;

  word_t registers [register_count];

  // register 0 is never written
  always_ff @(posedge clock) begin
    if (write.write_enabled && write.write_address != '0) begin
      registers[write.write_address] <= write.write_data;
    end
  end

  assign read_data_1 = (read_address_1 == '0) ? '0 : registers[read_address_1];
  assign read_data_2 = (read_address_2 == '0) ? '0 : registers[read_address_2];

endmodule

`default_nettype wire

// ==== source/stage_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module stage_control (
  input  logic                          clock,
  input  logic                          reset,
  input  pipeline_pkg::fetch_bus_t      fetch_bus,
  output logic                          allow_in,
  input  logic                          exec_allow_in,
  input  pipeline_pkg::decode_control_t control,
  input  isa_pkg::reg_address_t         rs,
  input  isa_pkg::reg_address_t         rt,
  input  pipeline_pkg::bypass_bus_t     exec_bypass,
  input  pipeline_pkg::bypass_bus_t     memory_bypass,
  output pipeline_pkg::fetch_bus_t      held,
  output logic                          out_valid
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  logic stage_valid;
  word_t held_program_count;
  instruction_t held_instruction;
  logic branch_compares;
  logic load_use_stall;
  logic branch_stall;
  logic ready;

  // entry will write a source that this instruction reads
  function automatic logic targets_source(
    input bypass_bus_t entry,
    input reg_address_t rs_address,
    input reg_address_t rt_address,
    input logic rs_used,
    input logic rt_used
  );
    logic rs_hit;
    logic rt_hit;
    rs_hit = rs_used && entry.write_register == rs_address;
    rt_hit = rt_used && entry.write_register == rt_address;
    return entry.valid && entry.write_register != '0 && (rs_hit || rt_hit);
  endfunction

  assign branch_compares = control.branch_kind inside {branch_eq, branch_ne, branch_register};

  assign load_use_stall =
    (!exec_bypass.data_valid &&
      targets_source(exec_bypass, rs, rt, control.uses_rs, control.uses_rt)) ||
    (!memory_bypass.data_valid &&
      targets_source(memory_bypass, rs, rt, control.uses_rs, control.uses_rt));

  // branches compare in decode, so anything still in execute is too late
  assign branch_stall = branch_compares &&
    targets_source(exec_bypass, rs, rt, control.uses_rs, control.uses_rt);

  assign ready = !(load_use_stall || branch_stall);
  assign allow_in = !stage_valid || (ready && exec_allow_in);
  assign out_valid = stage_valid && ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else if (allow_in) begin
      stage_valid <= fetch_bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_bus.valid && allow_in) begin
      held_program_count <= fetch_bus.program_count;
      held_instruction <= fetch_bus.instruction;
    end
  end

  assign held = '{
    valid: stage_valid,
    program_count: held_program_count,
    instruction: held_instruction
  };

endmodule

`default_nettype wire
